/* hw/ibuf_pkg.sv */
package ibuf_pkg;

  // one buffered instruction slot
  typedef struct packed {
    logic [31:0] pc;     // fetch address of the slot
    logic [31:0] instr;  // raw instruction word
  } ibuf_entry_t;

  // default FIFO depth, must stay a power of two
  localparam int IBUF_DEPTH = 16;

  // fetch bundle width, push lanes into the FIFO
  localparam int FETCH_W = 4;

  // pop lanes and decoder output lanes
  localparam int ISSUE_W = 2;

  // decoder credits held by dispatch after reset
  localparam int DISP_CREDITS = 4;

endpackage

/* hw/multi_fifo.sv */
`timescale 1ns/1ps

// circular buffer with several write and read lanes per cycle
// lanes are packed from lane 0, so push and pop are thermometer masks
module multi_fifo #(
  parameter int DEPTH  = 16,
  parameter int PUSH_W = 4,
  parameter int POP_W  = 2
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               clear,
  input  logic [PUSH_W-1:0]                  push,
  input  ibuf_pkg::ibuf_entry_t [PUSH_W-1:0] datain,
  input  logic [POP_W-1:0]                   pop,
  output ibuf_pkg::ibuf_entry_t [POP_W-1:0]  dataout,
  output logic                               empty,
  output logic [POP_W-1:1]                   almost_empty
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = PTR_W + 1;

  ibuf_pkg::ibuf_entry_t mem [DEPTH];

  logic [PTR_W-1:0] wptr;
  logic [PTR_W-1:0] rptr;
  logic [CNT_W-1:0] count;       // occupied entries, 0 to DEPTH
  logic [CNT_W-1:0] next_count;
  logic [CNT_W-1:0] push_count;
  logic [CNT_W-1:0] pop_count;
  logic [CNT_W-1:0] wptr_sum;
  logic [CNT_W-1:0] rptr_sum;

  logic [PTR_W-1:0] wr_idx [PUSH_W];
  logic [PTR_W-1:0] rd_idx [POP_W];

  // number of active request bits on each side
  always_comb begin
    push_count = '0;
    for (int k = 0; k < PUSH_W; k++) begin
      push_count = push_count + CNT_W'(push[k]);
    end
  end

  always_comb begin
    pop_count = '0;
    for (int k = 0; k < POP_W; k++) begin
      pop_count = pop_count + CNT_W'(pop[k]);
    end
  end

  // wrap is free since DEPTH is a power of two
  assign wptr_sum   = {1'b0, wptr} + push_count;
  assign rptr_sum   = {1'b0, rptr} + pop_count;
  assign next_count = count + push_count - pop_count;

  // per-lane addresses relative to the pointers
  for (genvar k = 0; k < PUSH_W; k++) begin : gen_wr_idx
    assign wr_idx[k] = wptr + PTR_W'(k);
  end

  for (genvar k = 0; k < POP_W; k++) begin : gen_rd_idx
    assign rd_idx[k]  = rptr + PTR_W'(k);
    assign dataout[k] = mem[rd_idx[k]];
  end

  // storage, written lane by lane
  always_ff @(posedge clk) begin
    for (int k = 0; k < PUSH_W; k++) begin
      if (push[k]) begin
        mem[wr_idx[k]] <= datain[k];
      end
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else if (clear) begin
      wptr  <= '0;   // held data is simply abandoned
      rptr  <= '0;
      count <= '0;
    end else begin
      if (|push) begin
        wptr <= wptr_sum[PTR_W-1:0];
      end
      if (|pop) begin
        rptr <= rptr_sum[PTR_W-1:0];
      end
      if ((|push) || (|pop)) begin
        count <= next_count;
      end
    end
  end

  // status flags
  assign empty = (count == '0);

  // almost_empty[i] set when at most i entries are held
  for (genvar i = 1; i < POP_W; i++) begin : gen_almost_empty
    assign almost_empty[i] = (count <= CNT_W'(i));
  end

endmodule

/* hw/fetch_stage.sv */
`timescale 1ns/1ps

// squeezes the valid slots of a fetch bundle into the low lanes
// and registers them as FIFO push lanes
module fetch_stage #(
  parameter int PUSH_W = 4
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               flush,
  input  logic [PUSH_W-1:0]                  in_valid,
  input  ibuf_pkg::ibuf_entry_t [PUSH_W-1:0] in_entry,
  output logic [PUSH_W-1:0]                  push,
  output ibuf_pkg::ibuf_entry_t [PUSH_W-1:0] push_data
);

  logic [PUSH_W-1:0]                  pack_valid;
  ibuf_pkg::ibuf_entry_t [PUSH_W-1:0] pack_entry;

  // keep arrival order, each valid slot takes the next free low lane
  always_comb begin
    int slot;
    slot       = 0;
    pack_valid = '0;
    pack_entry = '0;
    for (int k = 0; k < PUSH_W; k++) begin
      if (in_valid[k]) begin
        pack_valid[slot] = 1'b1;
        pack_entry[slot] = in_entry[k];
        slot++;
      end
    end
  end

  // lane valids, dropped on flush
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      push <= '0;
    end else if (flush) begin
      push <= '0;  // squash the bundle in flight
    end else begin
      push <= pack_valid;
    end
  end

  // payload only, qualified by push
  always_ff @(posedge clk) begin
    push_data <= pack_entry;
  end

endmodule

/* hw/dispatch_stage.sv */
`timescale 1ns/1ps

// pops up to POP_W entries per cycle toward the decoder
// bounded by FIFO occupancy and the downstream credit count
module dispatch_stage #(
  parameter int POP_W   = 2,
  parameter int CREDITS = 4
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              flush,
  input  ibuf_pkg::ibuf_entry_t [POP_W-1:0] dataout,
  input  logic                              empty,
  input  logic [POP_W-1:1]                  almost_empty,
  input  logic                              down_credit,
  output logic [POP_W-1:0]                  pop,
  output logic [$clog2(POP_W+1)-1:0]        up_credit,
  output logic [POP_W-1:0]                  out_valid,
  output ibuf_pkg::ibuf_entry_t [POP_W-1:0] out_entry
);

  localparam int CNT_W  = $clog2(POP_W + 1);
  localparam int CRED_W = $clog2(CREDITS + 1);

  logic [CRED_W-1:0] credit_q;  // decoder slots still free
  logic [CNT_W-1:0]  n_pop;

  // pop count = min(POP_W, occupancy, credits), zero on flush
  always_comb begin
    int avail;
    int lim;
    avail = POP_W;  // at least POP_W held unless a flag says otherwise
    for (int i = POP_W - 1; i >= 1; i--) begin
      if (almost_empty[i]) begin
        avail = i;  // lowest set flag is the exact count
      end
    end
    if (empty) begin
      avail = 0;
    end
    lim = avail;
    if (int'(credit_q) < lim) begin
      lim = int'(credit_q);
    end
    if (flush) begin
      lim = 0;
    end
    n_pop = CNT_W'(lim);
  end

  // pop mask packed from lane 0
  for (genvar k = 0; k < POP_W; k++) begin : gen_pop
    assign pop[k] = (CNT_W'(k) < n_pop);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_q  <= CRED_W'(CREDITS);
      out_valid <= '0;
      up_credit <= '0;
    end else begin
      // one credit back per decoder pulse, one spent per pop
      credit_q  <= credit_q + CRED_W'(down_credit) - CRED_W'(n_pop);
      out_valid <= pop;
      up_credit <= n_pop;  // frees FIFO slots for the fetch source
    end
  end

  // output payload, meaningful only under out_valid
  always_ff @(posedge clk) begin
    out_entry <= dataout;
  end

endmodule

/* hw/ibuf_top.sv */
`timescale 1ns/1ps

// instruction buffer: fetch compaction, multi-lane FIFO, dispatch
module ibuf_top #(
  parameter int DEPTH   = ibuf_pkg::IBUF_DEPTH,
  parameter int PUSH_W  = ibuf_pkg::FETCH_W,
  parameter int POP_W   = ibuf_pkg::ISSUE_W,
  parameter int CREDITS = ibuf_pkg::DISP_CREDITS
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               flush,
  input  logic [PUSH_W-1:0]                  in_valid,
  input  ibuf_pkg::ibuf_entry_t [PUSH_W-1:0] in_entry,
  output logic [$clog2(POP_W+1)-1:0]         up_credit,
  output logic [POP_W-1:0]                   out_valid,
  output ibuf_pkg::ibuf_entry_t [POP_W-1:0]  out_entry,
  input  logic                               down_credit
);

  logic [PUSH_W-1:0]                  push;
  ibuf_pkg::ibuf_entry_t [PUSH_W-1:0] push_data;
  logic [POP_W-1:0]                   pop;
  ibuf_pkg::ibuf_entry_t [POP_W-1:0]  dataout;
  logic                               empty;
  logic [POP_W-1:1]                   almost_empty;

  fetch_stage #(
    .PUSH_W (PUSH_W)
  ) fetch_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush     (flush),
    .in_valid  (in_valid),
    .in_entry  (in_entry),
    .push      (push),
    .push_data (push_data)
  );

  // no full check on push, upstream credits guarantee room
  multi_fifo #(
    .DEPTH  (DEPTH),
    .PUSH_W (PUSH_W),
    .POP_W  (POP_W)
  ) fifo_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .clear        (flush),
    .push         (push),
    .datain       (push_data),
    .pop          (pop),
    .dataout      (dataout),
    .empty        (empty),
    .almost_empty (almost_empty)
  );

  dispatch_stage #(
    .POP_W   (POP_W),
    .CREDITS (CREDITS)
  ) dispatch_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush        (flush),     // inhibits pops this cycle
    .dataout      (dataout),
    .empty        (empty),
    .almost_empty (almost_empty),
    .down_credit  (down_credit),
    .pop          (pop),
    .up_credit    (up_credit),
    .out_valid    (out_valid),
    .out_entry    (out_entry)
  );

endmodule

/* dv/ibuf_vectors.svh */
`ifndef IBUF_VECTORS_SVH
`define IBUF_VECTORS_SVH

// an empty mask without flush idles until buffer and decoder have drained
typedef struct packed {
  logic [ibuf_pkg::FETCH_W-1:0] mask;    // valid slots of the bundle
  logic [31:0]                  pc;      // slot k gets pc + 4k
  logic [7:0]                   period;  // decoder credit every nth cycle, 0 holds it low
  logic                         flush;   // flush in the cycle after the bundle
} vec_row_t;

localparam int NUM_ROWS = 28;

localparam vec_row_t VEC_TABLE [NUM_ROWS] = '{
  // holes and ordering, decoder keeps up
  '{4'b0001, 32'h0000_1000, 8'd1, 1'b0},
  '{4'b1010, 32'h0000_1100, 8'd1, 1'b0},
  '{4'b0110, 32'h0000_1200, 8'd1, 1'b0},
  '{4'b1111, 32'h0000_1300, 8'd1, 1'b0},
  '{4'b1001, 32'h0000_1400, 8'd1, 1'b0},
  '{4'b0100, 32'h0000_1500, 8'd2, 1'b0},
  '{4'b1101, 32'h0000_1600, 8'd3, 1'b0},
  '{4'b0000, 32'h0000_0000, 8'd1, 1'b0},
  // sixteen slot burst
  '{4'b1111, 32'h0000_2000, 8'd1, 1'b0},
  '{4'b1111, 32'h0000_2100, 8'd1, 1'b0},
  '{4'b1111, 32'h0000_2200, 8'd1, 1'b0},
  '{4'b1111, 32'h0000_2300, 8'd1, 1'b0},
  '{4'b0000, 32'h0000_0000, 8'd1, 1'b0},
  // decoder stalls, FIFO fills with 16 slots
  '{4'b1111, 32'h0000_3000, 8'd0, 1'b0},
  '{4'b0111, 32'h0000_3100, 8'd0, 1'b0},
  '{4'b1111, 32'h0000_3200, 8'd0, 1'b0},
  '{4'b1110, 32'h0000_3300, 8'd0, 1'b0},
  '{4'b1100, 32'h0000_3400, 8'd0, 1'b0},
  '{4'b0000, 32'h0000_0000, 8'd2, 1'b0},
  // flush over a well filled FIFO
  '{4'b1111, 32'h0000_4000, 8'd0, 1'b0},
  '{4'b1111, 32'h0000_4100, 8'd0, 1'b0},
  '{4'b1111, 32'h0000_4200, 8'd0, 1'b0},
  '{4'b0011, 32'h0000_4300, 8'd0, 1'b1},
  '{4'b0101, 32'h0000_5000, 8'd1, 1'b0},
  '{4'b1111, 32'h0000_5100, 8'd1, 1'b0},
  // flush while entries are flowing
  '{4'b1011, 32'h0000_6000, 8'd1, 1'b1},
  '{4'b0010, 32'h0000_7000, 8'd1, 1'b0},
  '{4'b1111, 32'h0000_7100, 8'd4, 1'b0}
};

`endif

/* dv/tb_ibuf.sv */
`timescale 1ns/1ps

module tb_ibuf;

  localparam int DEPTH   = ibuf_pkg::IBUF_DEPTH;
  localparam int PUSH_W  = ibuf_pkg::FETCH_W;
  localparam int POP_W   = ibuf_pkg::ISSUE_W;
  localparam int CREDITS = ibuf_pkg::DISP_CREDITS;

  `include "ibuf_vectors.svh"

  localparam int WATCHDOG_CYCLES = NUM_ROWS * 40 + 200;

  logic                               clk = 1'b0;
  logic                               rst_n;
  logic                               flush;
  logic [PUSH_W-1:0]                  in_valid;
  ibuf_pkg::ibuf_entry_t [PUSH_W-1:0] in_entry;
  logic [$clog2(POP_W+1)-1:0]         up_credit;
  logic [POP_W-1:0]                   out_valid;
  ibuf_pkg::ibuf_entry_t [POP_W-1:0]  out_entry;
  logic                               down_credit;

  ibuf_pkg::ibuf_entry_t ref_q [$];  // expected entries, oldest first
  integer seed;
  int credits;                       // upstream credits held by the fetch source
  int outstanding     = 0;           // entries in the decoder, credit not yet returned
  int cycle_count     = 0;
  int pulses_total    = 0;
  int presented_total = 0;
  int up_total        = 0;
  bit flush_pending   = 1'b0;

  ibuf_top dut_i (.*);

  always #5 clk = ~clk;

  task automatic end_with_failure();
    $display(">>> FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_entry(input string name, input ibuf_pkg::ibuf_entry_t exp_val,
                             input ibuf_pkg::ibuf_entry_t act_val);
    if (act_val !== exp_val) begin
      $display("ERROR %s: expected pc %h instr %h, actual pc %h instr %h",
               name, exp_val.pc, exp_val.instr, act_val.pc, act_val.instr);
      end_with_failure();
    end
  endtask

  task automatic check_count(input string name, input int exp_val, input int act_val);
    if (act_val != exp_val) begin
      $display("ERROR %s: expected %0d, actual %0d", name, exp_val, act_val);
      end_with_failure();
    end
  endtask

  // one clock, then collect freed slots and play the decoder
  task automatic step_cycle(input int period);
    @(posedge clk);
    #1;
    cycle_count++;
    in_valid = '0;
    flush    = 1'b0;
    credits += int'(up_credit);
    if (flush_pending) begin
      check_count("out_valid after flush", 0, int'(out_valid));
      check_count("up_credit after flush", 0, int'(up_credit));
      ref_q.delete();  // unseen entries died in the flush
      credits       = DEPTH;
      flush_pending = 1'b0;
    end
    if (credits > DEPTH) begin
      $display("fetch source got back %0d credits, more than the FIFO depth", credits);
      end_with_failure();
    end
    down_credit = 1'b0;
    if (period > 0 && cycle_count % period == 0 && outstanding > 0) begin
      down_credit = 1'b1;  // decoder hands one slot back
      outstanding--;
      pulses_total++;
    end
  endtask

  task automatic send_row(input vec_row_t row);
    int period;
    int slots;
    int held;
    ibuf_pkg::ibuf_entry_t ent;
    period = int'(row.period);
    slots  = $countones(row.mask);
    step_cycle(period);
    while (credits < slots) begin
      step_cycle(period);
    end
    // entries still sitting in the fetch register and FIFO
    held = ref_q.size() - $countones(out_valid);
    if (DEPTH - held - slots < 0) begin
      $display("upstream credits would go negative sending pc %h", row.pc);
      end_with_failure();
    end
    for (int k = 0; k < PUSH_W; k++) begin
      ent.pc      = row.pc + 32'(4 * k);
      ent.instr   = $random(seed);
      in_entry[k] = ent;
      if (row.mask[k]) begin
        ref_q.push_back(ent);  // compacted order is plain lane order
      end
    end
    in_valid = row.mask;
    credits -= slots;
    if (row.flush) begin
      step_cycle(period);
      flush         = 1'b1;
      flush_pending = 1'b1;
    end
  endtask

  task automatic drain_buffer(input int period);
    step_cycle(period);
    while (ref_q.size() != 0 || outstanding != 0) begin
      step_cycle(period);
    end
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    int nlanes;
    ibuf_pkg::ibuf_entry_t exp_entry;
    if (rst_n) begin
      nlanes = $countones(out_valid);
      check_count("out_valid packed from lane 0", (1 << nlanes) - 1, int'(out_valid));
      check_count("up_credit against presented lanes", nlanes, int'(up_credit));
      for (int k = 0; k < POP_W; k++) begin
        if (out_valid[k]) begin
          if (ref_q.size() == 0) begin
            $display("out lane %0d showed pc %h with no entry expected", k, out_entry[k].pc);
            end_with_failure();
          end else begin
            exp_entry = ref_q.pop_front();
            check_entry($sformatf("out lane %0d", k), exp_entry, out_entry[k]);
          end
        end
      end
      presented_total += nlanes;
      up_total        += int'(up_credit);
      outstanding     += nlanes;
      if (presented_total > CREDITS + pulses_total) begin
        $display("%0d entries presented but only %0d decoder credits granted",
                 presented_total, CREDITS + pulses_total);
        end_with_failure();
      end
    end
  end

  initial begin
    seed        = 32'h86ae;
    credits     = DEPTH;
    rst_n       = 1'b0;
    flush       = 1'b0;
    in_valid    = '0;
    in_entry    = '0;
    down_credit = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int i = 0; i < 3; i++) begin
      step_cycle(0);
      check_count("out_valid after reset", 0, int'(out_valid));
      check_count("up_credit after reset", 0, int'(up_credit));
    end
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (VEC_TABLE[r].mask == '0 && !VEC_TABLE[r].flush) begin
        drain_buffer(int'(VEC_TABLE[r].period));
      end else begin
        send_row(VEC_TABLE[r]);
      end
    end
    drain_buffer(1);
    repeat (4) step_cycle(1);  // nothing more may come out
    check_count("up_credit sum against presented entries", presented_total, up_total);
    $display(">>> PASS");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the test did not finish", WATCHDOG_CYCLES);
    end_with_failure();
  end

endmodule

/* files.f */
+incdir+dv
hw/ibuf_pkg.sv
hw/multi_fifo.sv
hw/fetch_stage.sv
hw/dispatch_stage.sv
hw/ibuf_top.sv
dv/tb_ibuf.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ibuf
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary
PASS_MSG  ?= >>> PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard dv/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qxF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
